// File: Makefile
# Verilator build and run for the global buffer testbench

VERILATOR ?= verilator
TOP       ?= global_buffer_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
rtl/glb_pkg.sv
rtl/glb_bank.sv
rtl/glb_strm_reader.sv
rtl/glb_proc_router.sv
rtl/glb_tile.sv
rtl/global_buffer.sv
verif/glb_properties.sv
verif/global_buffer_tb.sv

// File: rtl/glb_bank.sv
`timescale 1ns/1ns

module glb_bank (
    input  logic                                  clk,
    input  logic                                  rst,

    // processor side, already claimed by the router
    input  glb_pkg::proc_packet_t                 proc_req,

    // stream side
    input  logic                                  strm_req,
    input  logic [glb_pkg::WORD_ADDR_WIDTH-1:0]   strm_word,
    output logic                                  strm_grant,

    // read results
    output logic                                  proc_rd_valid,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0]   proc_rd_data,
    output logic                                  strm_rd_valid,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0]   strm_rd_data
);

    import glb_pkg::*;

    logic [BANK_DATA_WIDTH-1:0] mem [BANK_DEPTH];

    logic                       proc_active;
    logic [WORD_ADDR_WIDTH-1:0] rd_word;
    logic [BANK_DATA_WIDTH-1:0] rd_data_q;

    // any processor access holds the bank this cycle
    assign proc_active = proc_req.wr_en || proc_req.rd_en;
    assign strm_grant  = strm_req && !proc_active;

    // read address follows the winner
    assign rd_word = proc_active ? proc_req.addr.f.word : strm_word;

    // byte strobe write
    always_ff @(posedge clk) begin
        if (proc_req.wr_en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (proc_req.wr_strb[b]) begin
                    mem[proc_req.addr.f.word][b*8 +: 8] <= proc_req.data[b*8 +: 8];
                end
            end
        end
    end

    // one cycle read, old data on a same cycle write
    always_ff @(posedge clk) begin
        rd_data_q <= mem[rd_word];
    end

    // result ownership
    always_ff @(posedge clk) begin
        if (rst) begin
            proc_rd_valid <= 1'b0;
            strm_rd_valid <= 1'b0;
        end else begin
            proc_rd_valid <= proc_req.rd_en;
            strm_rd_valid <= strm_grant;
        end
    end

    // one data register feeds both sides
    assign proc_rd_data = rd_data_q;
    assign strm_rd_data = rd_data_q;

endmodule

// File: rtl/glb_pkg.sv
package glb_pkg;

    // bank word and strobe sizes
    localparam int BANK_DATA_WIDTH = 64;
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;

    // address fields
    localparam int TILE_SEL_WIDTH    = 4;
    localparam int WORD_ADDR_WIDTH   = 8;
    localparam int BYTE_OFFSET_WIDTH = 3;
    localparam int GLB_ADDR_WIDTH    = TILE_SEL_WIDTH + WORD_ADDR_WIDTH + BYTE_OFFSET_WIDTH;

    // words per bank
    localparam int BANK_DEPTH = 1 << WORD_ADDR_WIDTH;

    // one more bit than the word field, so a full bank fits in a count
    localparam int WORD_CNT_WIDTH = WORD_ADDR_WIDTH + 1;

    // tile view of an address, msb first
    typedef struct packed {
        logic [TILE_SEL_WIDTH-1:0]    tile;
        logic [WORD_ADDR_WIDTH-1:0]   word;
        logic [BYTE_OFFSET_WIDTH-1:0] byte_sel;
    } glb_addr_fields_t;

    // global address, flat for the processor, split inside the tiles
    typedef union packed {
        logic [GLB_ADDR_WIDTH-1:0] flat;
        glb_addr_fields_t          f;
    } glb_addr_t;

    // eastbound processor request
    typedef struct packed {
        logic                       wr_en;
        logic                       rd_en;
        logic [BANK_STRB_WIDTH-1:0] wr_strb;
        glb_addr_t                  addr;
        logic [BANK_DATA_WIDTH-1:0] data;
    } proc_packet_t;

    // westbound read response
    typedef struct packed {
        logic                       valid;
        glb_addr_t                  addr;
        logic [BANK_DATA_WIDTH-1:0] data;
    } rdrs_packet_t;

    // per tile stream setup
    typedef struct packed {
        logic [WORD_ADDR_WIDTH-1:0] start_word;
        logic [WORD_CNT_WIDTH-1:0]  num_words;
    } strm_cfg_t;

endpackage

// File: rtl/glb_proc_router.sv
`timescale 1ns/1ns

module glb_proc_router (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [glb_pkg::TILE_SEL_WIDTH-1:0]    tile_id,

    // eastbound packets
    input  glb_pkg::proc_packet_t                 proc_w2e_wsti,
    output glb_pkg::proc_packet_t                 proc_w2e_esto,

    // westbound responses
    input  glb_pkg::rdrs_packet_t                 rdrs_e2w_esti,
    output glb_pkg::rdrs_packet_t                 rdrs_e2w_wsto,

    // local bank
    output glb_pkg::proc_packet_t                 bank_req,
    input  logic                                  bank_rd_valid,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0]   bank_rd_data
);

    import glb_pkg::*;

    logic      is_local;
    glb_addr_t rd_addr_q;

    // packet addressed to this tile
    assign is_local = (proc_w2e_wsti.addr.f.tile == tile_id);

    // east register, local packets are consumed here
    always_ff @(posedge clk) begin
        if (rst) begin
            proc_w2e_esto.wr_en <= 1'b0;
            proc_w2e_esto.rd_en <= 1'b0;
        end else begin
            proc_w2e_esto <= proc_w2e_wsti;
            if (is_local) begin
                proc_w2e_esto.wr_en <= 1'b0;
                proc_w2e_esto.rd_en <= 1'b0;
            end
        end
    end

    // bank request register, one cycle to match the forward hop
    always_ff @(posedge clk) begin
        if (rst) begin
            bank_req.wr_en <= 1'b0;
            bank_req.rd_en <= 1'b0;
        end else begin
            bank_req <= proc_w2e_wsti;
            if (!is_local) begin
                bank_req.wr_en <= 1'b0;
                bank_req.rd_en <= 1'b0;
            end
        end
    end

    // address of the read now in the bank
    always_ff @(posedge clk) begin
        if (bank_req.rd_en) begin
            rd_addr_q <= bank_req.addr;
        end
    end

    // west register, local result takes the slot when present
    always_ff @(posedge clk) begin
        if (rst) begin
            rdrs_e2w_wsto.valid <= 1'b0;
        end else if (bank_rd_valid) begin
            rdrs_e2w_wsto.valid <= 1'b1;
            rdrs_e2w_wsto.addr  <= rd_addr_q;
            rdrs_e2w_wsto.data  <= bank_rd_data;
        end else begin
            rdrs_e2w_wsto <= rdrs_e2w_esti;
        end
    end

endmodule

// File: rtl/glb_strm_reader.sv
`timescale 1ns/1ns

module glb_strm_reader #(
    parameter int STRM_CREDITS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // stream setup and flow control
    input  logic                                  start_pulse,
    input  glb_pkg::strm_cfg_t                    cfg,
    input  logic                                  credit,

    // bank read port
    output logic                                  rd_req,
    output logic [glb_pkg::WORD_ADDR_WIDTH-1:0]   rd_word,
    input  logic                                  rd_grant,
    input  logic                                  rd_valid,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0]   rd_data,

    // toward the fabric
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0]   stream_data,
    output logic                                  stream_valid,
    output logic                                  done_pulse
);

    import glb_pkg::*;

    localparam int CRD_WIDTH = $clog2(STRM_CREDITS + 1);

    logic                       busy;
    logic [WORD_ADDR_WIDTH-1:0] cur_word;
    logic [WORD_CNT_WIDTH-1:0]  remaining;
    logic [CRD_WIDTH-1:0]       credit_cnt;
    logic                       last_issued_q;

    // ask only with words left and a credit in hand
    assign rd_req  = busy && (remaining != '0) && (credit_cnt != '0);
    assign rd_word = cur_word;

    // word and count tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            remaining <= '0;
        end else if (!busy) begin
            // zero length start is dropped
            if (start_pulse && (cfg.num_words != '0)) begin
                busy      <= 1'b1;
                cur_word  <= cfg.start_word;
                remaining <= cfg.num_words;
            end
        end else begin
            if (rd_grant) begin
                cur_word  <= cur_word + 1'b1;
                remaining <= remaining - 1'b1;
            end
            // free again once the final word is out of the bank
            if (last_issued_q) begin
                busy <= 1'b0;
            end
        end
    end

    // one credit per granted word, one back per fabric pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CRD_WIDTH'(STRM_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CRD_WIDTH'(rd_grant) + CRD_WIDTH'(credit);
        end
    end

    // grant of the final word, then done a cycle after its delivery
    always_ff @(posedge clk) begin
        if (rst) begin
            last_issued_q <= 1'b0;
            done_pulse    <= 1'b0;
        end else begin
            last_issued_q <= rd_grant && (remaining == WORD_CNT_WIDTH'(1));
            done_pulse    <= last_issued_q;
        end
    end

    // bank output already registered
    assign stream_data  = rd_data;
    assign stream_valid = rd_valid;

endmodule

// File: rtl/glb_tile.sv
`timescale 1ns/1ns

module glb_tile #(
    parameter int STRM_CREDITS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [glb_pkg::TILE_SEL_WIDTH-1:0]    tile_id,

    // processor packet chain
    input  glb_pkg::proc_packet_t                 proc_w2e_wsti,
    output glb_pkg::proc_packet_t                 proc_w2e_esto,

    // read response chain
    input  glb_pkg::rdrs_packet_t                 rdrs_e2w_esti,
    output glb_pkg::rdrs_packet_t                 rdrs_e2w_wsto,

    // stream control and output
    input  logic                                  strm_start_pulse,
    input  glb_pkg::strm_cfg_t                    strm_cfg,
    input  logic                                  stream_credit,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0]   stream_data,
    output logic                                  stream_valid,
    output logic                                  interrupt_pulse
);

    import glb_pkg::*;

    // router to bank
    proc_packet_t                bank_req;
    logic                        bank_rd_valid;
    logic [BANK_DATA_WIDTH-1:0]  bank_rd_data;

    // reader to bank
    logic                        strm_req;
    logic [WORD_ADDR_WIDTH-1:0]  strm_word;
    logic                        strm_grant;
    logic                        strm_rd_valid;
    logic [BANK_DATA_WIDTH-1:0]  strm_rd_data;

    // processor side
    glb_proc_router glb_proc_router (
        .clk           (clk),
        .rst           (rst),
        .tile_id       (tile_id),
        .proc_w2e_wsti (proc_w2e_wsti),
        .proc_w2e_esto (proc_w2e_esto),
        .rdrs_e2w_esti (rdrs_e2w_esti),
        .rdrs_e2w_wsto (rdrs_e2w_wsto),
        .bank_req      (bank_req),
        .bank_rd_valid (bank_rd_valid),
        .bank_rd_data  (bank_rd_data)
    );

    // fabric side, done pulse becomes the tile interrupt
    glb_strm_reader #(
        .STRM_CREDITS  (STRM_CREDITS)
    ) glb_strm_reader (
        .clk           (clk),
        .rst           (rst),
        .start_pulse   (strm_start_pulse),
        .cfg           (strm_cfg),
        .credit        (stream_credit),
        .rd_req        (strm_req),
        .rd_word       (strm_word),
        .rd_grant      (strm_grant),
        .rd_valid      (strm_rd_valid),
        .rd_data       (strm_rd_data),
        .stream_data   (stream_data),
        .stream_valid  (stream_valid),
        .done_pulse    (interrupt_pulse)
    );

    // shared bank, router wins
    glb_bank glb_bank (
        .clk           (clk),
        .rst           (rst),
        .proc_req      (bank_req),
        .strm_req      (strm_req),
        .strm_word     (strm_word),
        .strm_grant    (strm_grant),
        .proc_rd_valid (bank_rd_valid),
        .proc_rd_data  (bank_rd_data),
        .strm_rd_valid (strm_rd_valid),
        .strm_rd_data  (strm_rd_data)
    );

endmodule

// File: rtl/global_buffer.sv
`timescale 1ns/1ns

module global_buffer #(
    parameter int NUM_GLB_TILES = 4,
    parameter int STRM_CREDITS  = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // processor access
    input  logic                                  proc2glb_wr_en,
    input  logic [glb_pkg::BANK_STRB_WIDTH-1:0]   proc2glb_wr_strb,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0]   proc2glb_wr_data,
    input  logic                                  proc2glb_rd_en,
    input  glb_pkg::glb_addr_t                    proc2glb_addr,
    output logic                                  glb2proc_rd_valid,
    output glb_pkg::glb_addr_t                    glb2proc_rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0]   glb2proc_rd_data,

    // stream control
    input  logic [NUM_GLB_TILES-1:0]              strm_start_pulse,
    input  glb_pkg::strm_cfg_t                    strm_cfg [NUM_GLB_TILES],
    input  logic [NUM_GLB_TILES-1:0]              stream_credit_f2g,

    // glb to fabric stream
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0]   stream_data_g2f [NUM_GLB_TILES],
    output logic [NUM_GLB_TILES-1:0]              stream_valid_g2f,
    output logic [NUM_GLB_TILES-1:0]              interrupt_pulse
);

    import glb_pkg::*;

    // tile ids from the generate index
    logic [TILE_SEL_WIDTH-1:0] glb_tile_id [NUM_GLB_TILES];

    // processor packets, west to east
    proc_packet_t proc_w2e_wsti_int [NUM_GLB_TILES];
    proc_packet_t proc_w2e_esto_int [NUM_GLB_TILES];

    // read responses, east to west
    rdrs_packet_t rdrs_e2w_esti_int [NUM_GLB_TILES];
    rdrs_packet_t rdrs_e2w_wsto_int [NUM_GLB_TILES];

    // west edge takes the processor request
    always_comb begin
        proc_w2e_wsti_int[0].wr_en   = proc2glb_wr_en;
        proc_w2e_wsti_int[0].rd_en   = proc2glb_rd_en;
        proc_w2e_wsti_int[0].wr_strb = proc2glb_wr_strb;
        proc_w2e_wsti_int[0].addr    = proc2glb_addr;
        proc_w2e_wsti_int[0].data    = proc2glb_wr_data;
        for (int i = 1; i < NUM_GLB_TILES; i++) begin
            proc_w2e_wsti_int[i] = proc_w2e_esto_int[i-1];
        end
    end

    // nothing arrives from beyond the east end
    always_comb begin
        rdrs_e2w_esti_int[NUM_GLB_TILES-1] = '0;
        for (int i = 0; i < NUM_GLB_TILES - 1; i++) begin
            rdrs_e2w_esti_int[i] = rdrs_e2w_wsto_int[i+1];
        end
    end

    // tile 0 west output is the processor read port
    assign glb2proc_rd_valid = rdrs_e2w_wsto_int[0].valid;
    assign glb2proc_rd_addr  = rdrs_e2w_wsto_int[0].addr;
    assign glb2proc_rd_data  = rdrs_e2w_wsto_int[0].data;

    genvar i;
    generate
        for (i = 0; i < NUM_GLB_TILES; i++) begin : glb_tile_gen
            assign glb_tile_id[i] = TILE_SEL_WIDTH'(i);

            glb_tile #(
                .STRM_CREDITS     (STRM_CREDITS)
            ) glb_tile (
                .clk              (clk),
                .rst              (rst),
                .tile_id          (glb_tile_id[i]),
                .proc_w2e_wsti    (proc_w2e_wsti_int[i]),
                .proc_w2e_esto    (proc_w2e_esto_int[i]),
                .rdrs_e2w_esti    (rdrs_e2w_esti_int[i]),
                .rdrs_e2w_wsto    (rdrs_e2w_wsto_int[i]),
                .strm_start_pulse (strm_start_pulse[i]),
                .strm_cfg         (strm_cfg[i]),
                .stream_credit    (stream_credit_f2g[i]),
                .stream_data      (stream_data_g2f[i]),
                .stream_valid     (stream_valid_g2f[i]),
                .interrupt_pulse  (interrupt_pulse[i])
            );
        end : glb_tile_gen
    endgenerate

endmodule

// File: verif/glb_properties.sv
`timescale 1ns/1ns

module glb_properties #(
    parameter int NUM_GLB_TILES = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      proc2glb_rd_en,
    input  logic                      glb2proc_rd_valid,
    input  logic [NUM_GLB_TILES-1:0]  stream_valid_g2f,
    input  logic [NUM_GLB_TILES-1:0]  interrupt_pulse
);

    // reads taken in and not yet answered
    logic [7:0] rd_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending <= '0;
        end else begin
            rd_pending <= rd_pending + 8'(proc2glb_rd_en) - 8'(glb2proc_rd_valid);
        end
    end

    // stream outputs come out of reset low
    stream_idle_in_reset: assert property (@(posedge clk) rst |=> (stream_valid_g2f == '0))
        else $error("stream valid high during reset");

    // done interrupt is a single cycle pulse per tile
    irq_single_cycle: assert property (@(posedge clk) disable iff (rst)
        ((interrupt_pulse & $past(interrupt_pulse)) == '0))
        else $error("interrupt pulse held for two cycles");

    // no response without a read in flight
    rd_valid_after_issue: assert property (@(posedge clk) disable iff (rst)
        glb2proc_rd_valid |-> (rd_pending != '0))
        else $error("read response with no read issued");

endmodule

bind global_buffer glb_properties #(
    .NUM_GLB_TILES     (NUM_GLB_TILES)
) u_glb_properties (
    .clk               (clk),
    .rst               (rst),
    .proc2glb_rd_en    (proc2glb_rd_en),
    .glb2proc_rd_valid (glb2proc_rd_valid),
    .stream_valid_g2f  (stream_valid_g2f),
    .interrupt_pulse   (interrupt_pulse)
);

// File: verif/global_buffer_tb.sv
`timescale 1ns/1ns

module global_buffer_tb;

    import glb_pkg::*;

    localparam int          NUM_GLB_TILES  = 4;
    localparam int          STRM_CREDITS   = 4;
    localparam int          CLK_HALF       = 50;
    localparam int          DRIVE_DELAY    = 5;
    localparam int          RESET_CYCLES   = 8;
    localparam logic [31:0] SEED           = 32'h4208_312b;
    // generous estimate of all tests together
    localparam int          TEST_CYCLES    = 2000;
    localparam int          TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                        clk;
    logic                        rst;
    logic                        proc2glb_wr_en;
    logic [BANK_STRB_WIDTH-1:0]  proc2glb_wr_strb;
    logic [BANK_DATA_WIDTH-1:0]  proc2glb_wr_data;
    logic                        proc2glb_rd_en;
    glb_addr_t                   proc2glb_addr;
    logic                        glb2proc_rd_valid;
    glb_addr_t                   glb2proc_rd_addr;
    logic [BANK_DATA_WIDTH-1:0]  glb2proc_rd_data;
    logic [NUM_GLB_TILES-1:0]    strm_start_pulse;
    strm_cfg_t                   strm_cfg [NUM_GLB_TILES];
    logic [NUM_GLB_TILES-1:0]    stream_credit_f2g;
    logic [BANK_DATA_WIDTH-1:0]  stream_data_g2f [NUM_GLB_TILES];
    logic [NUM_GLB_TILES-1:0]    stream_valid_g2f;
    logic [NUM_GLB_TILES-1:0]    interrupt_pulse;

    // contents of every bank as the processor wrote them
    logic [BANK_DATA_WIDTH-1:0]  bank_model [NUM_GLB_TILES][BANK_DEPTH];

    // reads in flight, with the cycle each must arrive in
    glb_addr_t                   pend_addr [$];
    logic [BANK_DATA_WIDTH-1:0]  pend_data [$];
    int                          pend_due [$];
    bit                          resp_slot [TIMEOUT_CYCLES + 64];

    // open stream bookkeeping
    logic [BANK_DATA_WIDTH-1:0]  strm_exp [$];
    int                          strm_tile;
    int                          strm_len;
    int                          strm_got;
    int                          crd_returned;
    int                          crd_gap;
    int                          irq_cnt;

    int                          cycle;
    int                          wd_cycles;
    string                       cur_test;

    global_buffer #(
        .NUM_GLB_TILES     (NUM_GLB_TILES),
        .STRM_CREDITS      (STRM_CREDITS)
    ) u_dut (
        .clk               (clk),
        .rst               (rst),
        .proc2glb_wr_en    (proc2glb_wr_en),
        .proc2glb_wr_strb  (proc2glb_wr_strb),
        .proc2glb_wr_data  (proc2glb_wr_data),
        .proc2glb_rd_en    (proc2glb_rd_en),
        .proc2glb_addr     (proc2glb_addr),
        .glb2proc_rd_valid (glb2proc_rd_valid),
        .glb2proc_rd_addr  (glb2proc_rd_addr),
        .glb2proc_rd_data  (glb2proc_rd_data),
        .strm_start_pulse  (strm_start_pulse),
        .strm_cfg          (strm_cfg),
        .stream_credit_f2g (stream_credit_f2g),
        .stream_data_g2f   (stream_data_g2f),
        .stream_valid_g2f  (stream_valid_g2f),
        .interrupt_pulse   (interrupt_pulse)
    );

    always #CLK_HALF clk = ~clk;

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // watchdog on the free running clock
    always @(posedge clk) begin
        wd_cycles++;
        if (wd_cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic fail_plain(input string msg);
        $display("Error in %s: %s", cur_test, msg);
        abort_run();
    endtask

    task automatic check_rd(input glb_addr_t exp_addr, input logic [BANK_DATA_WIDTH-1:0] exp_data,
                            input glb_addr_t got_addr, input logic [BANK_DATA_WIDTH-1:0] got_data);
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            $display("FAILED %s: read expected addr 0x%h data 0x%h actual addr 0x%h data 0x%h",
                     cur_test, exp_addr.flat, exp_data, got_addr.flat, got_data);
            abort_run();
        end
    endtask

    task automatic check_strm_word(input logic [BANK_DATA_WIDTH-1:0] exp_word,
                                   input logic [BANK_DATA_WIDTH-1:0] got_word);
        if (got_word !== exp_word) begin
            $display("FAILED %s: stream word expected 0x%h actual 0x%h",
                     cur_test, exp_word, got_word);
            abort_run();
        end
    endtask

    task automatic check_count(input string what, input int exp_val, input int got_val);
        if (got_val != exp_val) begin
            $display("FAILED %s: %s expected %0d actual %0d", cur_test, what, exp_val, got_val);
            abort_run();
        end
    endtask

    // read valid, stream valids and interrupts must all be low
    task automatic verify_idle_outputs();
        logic [2*NUM_GLB_TILES:0] got;
        got = {glb2proc_rd_valid, stream_valid_g2f, interrupt_pulse};
        if (got !== '0) begin
            $display("FAILED %s: idle outputs expected 0x0 actual 0x%h", cur_test, got);
            abort_run();
        end
    endtask

    function automatic glb_addr_t make_addr(input int tile, input int word, input int byte_sel);
        glb_addr_t a;
        a.f.tile     = TILE_SEL_WIDTH'(tile);
        a.f.word     = WORD_ADDR_WIDTH'(word);
        a.f.byte_sel = BYTE_OFFSET_WIDTH'(byte_sel);
        return a;
    endfunction

    // responses are matched by address
    task automatic collect_read();
        int idx;
        int k;
        idx = -1;
        if (glb2proc_rd_valid === 1'b1) begin
            for (k = 0; k < pend_addr.size(); k++) begin
                if (pend_addr[k] == glb2proc_rd_addr) begin
                    idx = k;
                end
            end
            if (idx < 0) begin
                fail_plain("a read response carries an address with no pending read");
            end else begin
                check_rd(pend_addr[idx], pend_data[idx], glb2proc_rd_addr, glb2proc_rd_data);
                check_count("read arrival cycle", pend_due[idx], cycle);
                pend_addr.delete(idx);
                pend_data.delete(idx);
                pend_due.delete(idx);
            end
        end
    endtask

    task automatic collect_stream();
        int k;
        for (k = 0; k < NUM_GLB_TILES; k++) begin
            if (stream_valid_g2f[k] === 1'b1) begin
                if (k != strm_tile || strm_exp.size() == 0) begin
                    fail_plain("a stream word came out with no stream expecting it");
                end else begin
                    check_strm_word(strm_exp.pop_front(), stream_data_g2f[k]);
                    strm_got++;
                    if (strm_got - crd_returned > STRM_CREDITS) begin
                        fail_plain("more stream words outstanding than credits");
                    end
                end
            end
            if (interrupt_pulse[k] === 1'b1) begin
                if (k != strm_tile) begin
                    fail_plain("interrupt from a tile with no open stream");
                end else begin
                    irq_cnt++;
                    check_count("words before interrupt", strm_len, strm_got);
                end
            end
        end
    endtask

    // fabric returns one credit every crd_gap cycles for words it holds
    task automatic drive_credit();
        stream_credit_f2g = '0;
        if (strm_tile >= 0 && strm_got > crd_returned && (cycle % crd_gap) == 0) begin
            stream_credit_f2g[strm_tile] = 1'b1;
            crd_returned++;
        end
    endtask

    // outputs sampled after the edge, inputs driven right after
    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
        cycle++;
        collect_read();
        collect_stream();
        drive_credit();
    endtask

    task automatic issue_write(input int tile, input int word, input logic [7:0] strb,
                               input logic [BANK_DATA_WIDTH-1:0] data);
        int b;
        for (b = 0; b < BANK_STRB_WIDTH; b++) begin
            if (strb[b]) begin
                bank_model[tile][word][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        proc2glb_wr_en   = 1'b1;
        proc2glb_wr_strb = strb;
        proc2glb_wr_data = data;
        proc2glb_addr    = make_addr(tile, word, 0);
        tick();
        proc2glb_wr_en   = 1'b0;
    endtask

    task automatic issue_read(input int tile, input int word, input int byte_sel);
        glb_addr_t addr;
        int        due;
        addr = make_addr(tile, word, byte_sel);
        due  = cycle + 2 * tile + 3;
        // a local result replaces any response passing the same tile
        // so two arrivals may not share a cycle
        while (resp_slot[due]) begin
            tick();
            due = cycle + 2 * tile + 3;
        end
        resp_slot[due] = 1'b1;
        pend_addr.push_back(addr);
        pend_data.push_back(bank_model[tile][word]);
        pend_due.push_back(due);
        proc2glb_rd_en = 1'b1;
        proc2glb_addr  = addr;
        tick();
        proc2glb_rd_en = 1'b0;
    endtask

    task automatic wait_reads();
        while (pend_addr.size() > 0) begin
            tick();
        end
    endtask

    // random words, then idle until the writes have landed
    task automatic preload(input int tile, input int start, input int num);
        int k;
        for (k = 0; k < num; k++) begin
            issue_write(tile, (start + k) % BANK_DEPTH, 8'hff, {$urandom, $urandom});
        end
        repeat (8) tick();
    endtask

    task automatic start_stream(input int tile, input int start, input int num);
        strm_cfg[tile].start_word = WORD_ADDR_WIDTH'(start);
        strm_cfg[tile].num_words  = WORD_CNT_WIDTH'(num);
        strm_start_pulse[tile]    = 1'b1;
        tick();
        strm_start_pulse[tile]    = 1'b0;
    endtask

    task automatic open_stream(input int tile, input int start, input int num, input int gap);
        int k;
        strm_tile    = tile;
        strm_len     = num;
        strm_got     = 0;
        crd_returned = 0;
        irq_cnt      = 0;
        crd_gap      = gap;
        strm_exp.delete();
        for (k = 0; k < num; k++) begin
            strm_exp.push_back(bank_model[tile][(start + k) % BANK_DEPTH]);
        end
        start_stream(tile, start, num);
    endtask

    // wait for done, hand back all credits, then watch for stray words
    task automatic finish_stream();
        while (irq_cnt == 0) begin
            tick();
        end
        crd_gap = 1;
        while (crd_returned < strm_got) begin
            tick();
        end
        repeat (16) tick();
        check_count("stream words", strm_len, strm_got);
        check_count("interrupts", 1, irq_cnt);
        strm_tile = -1;
    endtask

    task automatic write_read_each_tile();
        int words [NUM_GLB_TILES*4];
        int t;
        int k;
        int base;
        cur_test = "write_read_each_tile";
        for (t = 0; t < NUM_GLB_TILES; t++) begin
            base = int'($urandom % 60) * 4;
            for (k = 0; k < 4; k++) begin
                words[t*4 + k] = base + k;
                issue_write(t, base + k, 8'hff, {$urandom, $urandom});
            end
        end
        for (t = 0; t < NUM_GLB_TILES; t++) begin
            for (k = 0; k < 4; k++) begin
                issue_read(t, words[t*4 + k], int'($urandom % 8));
            end
        end
        wait_reads();
    endtask

    task automatic byte_strobe_merge();
        int t;
        cur_test = "byte_strobe_merge";
        for (t = 0; t < NUM_GLB_TILES; t++) begin
            issue_write(t, 240 + t, 8'hff, 64'h0123_4567_89ab_cdef);
            issue_write(t, 240 + t, 8'h0f, {$urandom, $urandom});
            issue_write(t, 240 + t, 8'ha5, {$urandom, $urandom});
            issue_write(t, 240 + t, 8'($urandom), {$urandom, $urandom});
            issue_read(t, 240 + t, 0);
        end
        wait_reads();
    endtask

    // order keeps every arrival cycle distinct
    task automatic back_to_back_reads();
        int order [4];
        int k;
        cur_test = "back_to_back_reads";
        order = '{3, 0, 1, 2};
        for (k = 0; k < 4; k++) begin
            issue_write(order[k], 50, 8'hff, {$urandom, $urandom});
        end
        for (k = 0; k < 4; k++) begin
            issue_read(order[k], 50, k);
        end
        wait_reads();
    endtask

    task automatic stream_with_credits();
        cur_test = "stream_with_credits";
        preload(1, 16, 12);
        open_stream(1, 16, 12, 3);
        finish_stream();
    endtask

    task automatic stream_under_proc_traffic();
        int k;
        cur_test = "stream_under_proc_traffic";
        preload(2, 64, 16);
        open_stream(2, 64, 16, 1);
        for (k = 0; k < 8; k++) begin
            issue_write(2, 200 + k, 8'hff, {$urandom, $urandom});
            issue_read(2, 200 + k, 0);
        end
        wait_reads();
        finish_stream();
    endtask

    task automatic start_while_busy();
        cur_test = "start_while_busy";
        preload(3, 32, 6);
        open_stream(3, 32, 6, 1);
        tick();
        // second setup differs in both fields
        start_stream(3, 100, 10);
        finish_stream();
    endtask

    initial begin
        int k;
        void'($urandom(SEED));
        clk               = 1'b0;
        rst               = 1'b1;
        proc2glb_wr_en    = 1'b0;
        proc2glb_wr_strb  = '0;
        proc2glb_wr_data  = '0;
        proc2glb_rd_en    = 1'b0;
        proc2glb_addr     = '0;
        strm_start_pulse  = '0;
        stream_credit_f2g = '0;
        for (k = 0; k < NUM_GLB_TILES; k++) begin
            strm_cfg[k] = '0;
        end
        cycle     = 0;
        wd_cycles = 0;
        strm_tile = -1;
        crd_gap   = 1;
        cur_test  = "reset";
        repeat (RESET_CYCLES) tick();
        rst = 1'b0;
        tick();
        verify_idle_outputs();
        write_read_each_tile();
        byte_strobe_merge();
        back_to_back_reads();
        stream_with_credits();
        stream_under_proc_traffic();
        start_while_busy();
        $display("Simulation PASSED");
        $finish;
    end

endmodule
